// ==== design/capture_controller.sv ====
// arming FSM, banking by active channel count, fill counters and full detection
`timescale 1ns/1ps

module capture_controller
  import sample_buffer_pkg::*;
(
  input  logic          capture_clk,
  input  logic          readout_reset,
  input  logic          capture_start,
  input  logic          capture_stop,
  input  logic          capture_sw_reset,
  input  active_count_t active_channels,
  input  capture_in_s   capture_in,
  output bank_write_s   bank_write,
  output depth_vector_t write_depth,
  output logic          capture_full,
  output logic          capture_armed
);

  capture_state_e state_q;
  depth_vector_t depth_q;

  // log2 of the active count, and the per-channel capacity it gives
  int bank_shift;
  channel_depth_t capacity;

  logic [CHANNELS-1:0] chan_we;
  logic fill_hit;

  ////////////////////////////////////////////////////////////////////////////
  // banking mode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (active_channels)
      active_count_t'(1): bank_shift = 0;
      active_count_t'(2): bank_shift = 1;
      default:            bank_shift = 2;
    endcase
    capacity = channel_depth_t'((BANK_DEPTH * CHANNELS) >> bank_shift);
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-channel write enables
  ////////////////////////////////////////////////////////////////////////////
  // the sample seen with stop is dropped; inactive channels never write
  always_comb begin
    fill_hit = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      chan_we[c] = (state_q == cap_armed) && !capture_stop && !capture_sw_reset &&
                   capture_in.valid[c] && (c < int'(active_channels)) &&
                   (depth_q[c] < capacity);
      if (chan_we[c] && (channel_depth_t'(depth_q[c] + 1'b1) == capacity)) begin
        fill_hit = 1'b1;
      end
    end
  end

  // bank b belongs to channel b mod A, and holds segment b div A of it
  always_comb begin
    int ch;
    int seg;
    for (int b = 0; b < CHANNELS; b++) begin
      ch = b % (1 << bank_shift);
      seg = b >> bank_shift;
      bank_write.en[b] = chan_we[ch] &&
                         (int'(depth_q[ch] >> $clog2(BANK_DEPTH)) == seg);
      bank_write.addr[b] = bank_addr_t'(depth_q[ch]);
      bank_write.data[b] = capture_in.data[ch];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and fill counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge capture_clk) begin
    if (readout_reset || capture_sw_reset) begin
      state_q <= cap_idle;
      depth_q <= '0;
    end else begin
      case (state_q)
        cap_idle, cap_full: begin
          // a new start always begins from empty banks
          if (capture_start) begin
            depth_q <= '0;
            state_q <= cap_armed;
          end
        end
        cap_armed: begin
          for (int c = 0; c < CHANNELS; c++) begin
            if (chan_we[c]) begin
              depth_q[c] <= depth_q[c] + 1'b1;
            end
          end
          if (fill_hit) begin
            state_q <= cap_full;
          end else if (capture_stop) begin
            state_q <= cap_idle;
          end
        end
        default: begin
          state_q <= cap_idle;
        end
      endcase
    end
  end

  assign write_depth = depth_q;
  assign capture_full = (state_q == cap_full);
  assign capture_armed = (state_q == cap_armed);

endmodule

// ==== design/readout_sequencer.sv ====
// header and sample read scheduling, tag delay line, skid buffer and last flag
`timescale 1ns/1ps

module readout_sequencer
  import sample_buffer_pkg::*;
(
  input  logic          capture_clk,
  input  logic          readout_reset,
  input  logic          readout_start,
  input  logic          readout_sw_reset,
  input  logic          capture_armed,
  input  active_count_t active_channels,
  input  depth_vector_t write_depth,
  output bank_sel_t     read_bank,
  output bank_addr_t    read_addr,
  input  sample_t       read_data,
  input  logic          readout_ready,
  output logic          readout_valid,
  output readout_word_s readout_word
);

  // travels alongside each read through the RAM latency
  typedef struct packed {
    logic header;
    readout_word_s word;
  } read_tag_s;

  readout_state_e state_q;
  active_count_t act_q;
  depth_vector_t depth_q;
  bank_sel_t hdr_q;
  bank_sel_t chan_q;
  channel_depth_t samp_q;

  int last_chan;
  logic no_samples;
  channel_depth_t cur_depth;
  logic have_sample;
  logic hdr_final;
  logic chan_final;
  logic issue;
  read_tag_s issue_tag;

  logic [READ_LATENCY-1:0] tag_valid_q;
  read_tag_s tag_q [READ_LATENCY];
  readout_word_s ret_word;

  readout_word_s skid_mem [SKID_DEPTH];
  skid_count_t wr_ptr_q;
  skid_count_t rd_ptr_q;
  skid_count_t fill_q;
  skid_count_t outstanding_q;
  logic push;
  logic pop;

  function automatic skid_count_t next_ptr(input skid_count_t ptr);
    if (ptr == skid_count_t'(SKID_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // item scheduling
  ////////////////////////////////////////////////////////////////////////////
  // highest active channel that holds data carries the last word
  always_comb begin
    last_chan = 0;
    no_samples = 1'b1;
    for (int c = 0; c < CHANNELS; c++) begin
      if ((c < int'(act_q)) && (depth_q[c] != '0)) begin
        last_chan = c;
        no_samples = 1'b0;
      end
    end
  end

  always_comb begin
    cur_depth = depth_q[chan_q];
    have_sample = (samp_q < cur_depth);
    hdr_final = (int'(hdr_q) + 1 >= int'(act_q));
    chan_final = (int'(chan_q) + 1 >= int'(act_q));

    // in-flight reads plus skid contents never exceed the skid size
    issue = (outstanding_q < skid_count_t'(SKID_DEPTH)) &&
            ((state_q == rd_headers) || ((state_q == rd_samples) && have_sample));

    issue_tag.header = (state_q == rd_headers);
    if (state_q == rd_headers) begin
      issue_tag.word.data = sample_t'(depth_q[hdr_q]);
      issue_tag.word.last = hdr_final && no_samples;
    end else begin
      issue_tag.word.data = '0;
      issue_tag.word.last = (int'(chan_q) == last_chan) &&
                            (channel_depth_t'(samp_q + 1'b1) == cur_depth);
    end

    // same banking rule as the capture side
    read_addr = bank_addr_t'(samp_q);
    read_bank = bank_sel_t'(int'(chan_q) +
                            int'(act_q) * int'(samp_q >> $clog2(BANK_DEPTH)));
  end

  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      state_q <= rd_idle;
      act_q <= '0;
      depth_q <= '0;
      hdr_q <= '0;
      chan_q <= '0;
      samp_q <= '0;
    end else begin
      case (state_q)
        rd_idle: begin
          if (readout_start && !capture_armed) begin
            act_q <= active_channels;
            depth_q <= write_depth;
            hdr_q <= '0;
            chan_q <= '0;
            samp_q <= '0;
            state_q <= rd_headers;
          end
        end
        rd_headers: begin
          if (issue) begin
            if (hdr_final) begin
              state_q <= rd_samples;
            end else begin
              hdr_q <= hdr_q + 1'b1;
            end
          end
        end
        rd_samples: begin
          if (issue) begin
            samp_q <= samp_q + 1'b1;
          end else if (!have_sample) begin
            // step to the next channel once this one is exhausted
            if (chan_final) begin
              state_q <= rd_drain;
            end else begin
              chan_q <= chan_q + 1'b1;
              samp_q <= '0;
            end
          end
        end
        rd_drain: begin
          // wait for the last word to leave the skid buffer
          if (outstanding_q == '0) begin
            state_q <= rd_idle;
          end
        end
        default: begin
          state_q <= rd_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tag delay line in step with the RAM pipeline
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      tag_valid_q <= '0;
    end else begin
      tag_valid_q <= {tag_valid_q[READ_LATENCY-2:0], issue};
    end
  end

  always_ff @(posedge capture_clk) begin
    tag_q[0] <= issue_tag;
    for (int i = 1; i < READ_LATENCY; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
  end

  always_comb begin
    ret_word = tag_q[READ_LATENCY-1].word;
    if (!tag_q[READ_LATENCY-1].header) begin
      ret_word.data = read_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // skid buffer and output handshake
  ////////////////////////////////////////////////////////////////////////////
  assign push = tag_valid_q[READ_LATENCY-1];
  assign pop = readout_valid && readout_ready;

  always_ff @(posedge capture_clk) begin
    if (push) begin
      skid_mem[wr_ptr_q] <= ret_word;
    end
  end

  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q <= '0;
      outstanding_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      fill_q <= fill_q + skid_count_t'(push) - skid_count_t'(pop);
      outstanding_q <= outstanding_q + skid_count_t'(issue) - skid_count_t'(pop);
    end
  end

  // head word is held until it transfers
  assign readout_valid = (fill_q != '0);
  assign readout_word = skid_mem[rd_ptr_q];

endmodule

// ==== design/sample_bank_ram.sv ====
// four sample banks with separate write ports and one pipelined read port
`timescale 1ns/1ps

module sample_bank_ram
  import sample_buffer_pkg::*;
(
  input  logic        capture_clk,
  input  bank_write_s bank_write,
  input  bank_sel_t   read_bank,
  input  bank_addr_t  read_addr,
  output sample_t     read_data
);

  // combinational read of every bank at the shared address
  sample_t bank_rd [CHANNELS];

  // read data pipeline with the output at stage READ_LATENCY-1
  sample_t read_pipe [READ_LATENCY];

  ////////////////////////////////////////////////////////////////////////////
  // banks
  ////////////////////////////////////////////////////////////////////////////
  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    sample_t mem [BANK_DEPTH];

    always_ff @(posedge capture_clk) begin
      if (bank_write.en[b]) begin
        mem[bank_write.addr[b]] <= bank_write.data[b];
      end
    end

    assign bank_rd[b] = mem[read_addr];
  end

  ////////////////////////////////////////////////////////////////////////////
  // read pipeline
  ////////////////////////////////////////////////////////////////////////////
  // a new read may start every cycle
  always_ff @(posedge capture_clk) begin
    read_pipe[0] <= bank_rd[read_bank];
    for (int i = 1; i < READ_LATENCY; i++) begin
      read_pipe[i] <= read_pipe[i-1];
    end
  end

  assign read_data = read_pipe[READ_LATENCY-1];

endmodule

// ==== design/sample_buffer.sv ====
// top level joining the capture controller, the sample banks and the readout sequencer
`timescale 1ns/1ps

module sample_buffer
  import sample_buffer_pkg::*;
(
  input  logic          capture_clk,
  input  logic          readout_reset,

  // capture side
  input  capture_in_s   capture_in,
  input  active_count_t active_channels,
  input  logic          capture_start,
  input  logic          capture_stop,
  input  logic          capture_sw_reset,
  output logic          capture_full,
  output logic          capture_armed,
  output depth_vector_t write_depth,

  // readout side
  input  logic          readout_start,
  input  logic          readout_sw_reset,
  input  logic          readout_ready,
  output logic          readout_valid,
  output readout_word_s readout_word
);

  bank_write_s bank_write;
  bank_sel_t read_bank;
  bank_addr_t read_addr;
  sample_t read_data;

  ////////////////////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////////////////////
  capture_controller capture_i (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .capture_start    (capture_start),
    .capture_stop     (capture_stop),
    .capture_sw_reset (capture_sw_reset),
    .active_channels  (active_channels),
    .capture_in       (capture_in),
    .bank_write       (bank_write),
    .write_depth      (write_depth),
    .capture_full     (capture_full),
    .capture_armed    (capture_armed)
  );

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////
  sample_bank_ram ram_i (
    .capture_clk (capture_clk),
    .bank_write  (bank_write),
    .read_bank   (read_bank),
    .read_addr   (read_addr),
    .read_data   (read_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // readout
  ////////////////////////////////////////////////////////////////////////////
  readout_sequencer readout_i (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .readout_start    (readout_start),
    .readout_sw_reset (readout_sw_reset),
    .capture_armed    (capture_armed),
    .active_channels  (active_channels),
    .write_depth      (write_depth),
    .read_bank        (read_bank),
    .read_addr        (read_addr),
    .read_data        (read_data),
    .readout_ready    (readout_ready),
    .readout_valid    (readout_valid),
    .readout_word     (readout_word)
  );

endmodule

// ==== design/sample_buffer_pkg.sv ====
// sizes, sample and depth types, capture and readout structs, FSM state enums
package sample_buffer_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int CHANNELS = 4;
  localparam int BANK_DEPTH = 64;
  localparam int SAMPLE_WIDTH = 16;
  localparam int READ_LATENCY = 4;

  // one slot per word that can be in the RAM pipeline plus one
  localparam int SKID_DEPTH = READ_LATENCY + 1;

  ////////////////////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;
  typedef logic [$clog2(CHANNELS)-1:0] bank_sel_t;

  // 1, 2 or 4
  typedef logic [$clog2(CHANNELS+1)-1:0] active_count_t;

  // 0 up to the full memory when a single channel is active
  typedef logic [$clog2(BANK_DEPTH*CHANNELS+1)-1:0] channel_depth_t;
  typedef channel_depth_t [CHANNELS-1:0] depth_vector_t;

  // skid buffer pointers and occupancy
  typedef logic [$clog2(SKID_DEPTH+1)-1:0] skid_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [CHANNELS-1:0] valid;
    sample_t [CHANNELS-1:0] data;
  } capture_in_s;

  // one write port per bank
  typedef struct packed {
    logic [CHANNELS-1:0] en;
    bank_addr_t [CHANNELS-1:0] addr;
    sample_t [CHANNELS-1:0] data;
  } bank_write_s;

  typedef struct packed {
    sample_t data;
    logic last;
  } readout_word_s;

  ////////////////////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    cap_idle,
    cap_armed,
    cap_full
  } capture_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_headers,
    rd_samples,
    rd_drain
  } readout_state_e;

endpackage

// ==== flist.f ====
+incdir+testbench
design/sample_buffer_pkg.sv
design/sample_bank_ram.sv
design/capture_controller.sv
design/readout_sequencer.sv
design/sample_buffer.sv
testbench/sample_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the sample buffer testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module sample_buffer_tb \
  -f flist.f -o sim_tb > build.log 2>&1 &&
{ ./obj_dir/sim_tb > sim.log 2>&1 || true; } &&
! grep -q "SOME TESTS FAILED" sim.log &&
grep -q "ALL TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

// ==== testbench/sample_buffer_model.svh ====
// LCG random source, value check task, per-channel model queues, capture model, stream prediction
`ifndef SAMPLE_BUFFER_MODEL_SVH
`define SAMPLE_BUFFER_MODEL_SVH

  ////////////////////////////////////////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////////////////////////////////////////
  logic [31:0] lcg_state = 32'd53448;

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // low bits of the LCG repeat quickly
    return lcg_state >> 8;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand_next() % 32'(hi - lo + 1));
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  sample_t model_q [CHANNELS][$];
  bit model_armed = 1'b0;
  bit model_full = 1'b0;
  readout_word_s expected_stream [$];

  // applies the inputs that the coming clock edge will sample
  task automatic model_capture_edge();
    int act;
    int cap;
    bit hit;
    act = int'(active_channels);
    cap = (BANK_DEPTH * CHANNELS) / act;
    hit = 1'b0;
    if (capture_sw_reset) begin
      for (int c = 0; c < CHANNELS; c++) begin
        model_q[c].delete();
      end
      model_armed = 1'b0;
      model_full = 1'b0;
    end else if (model_armed) begin
      // the sample that comes with stop is dropped
      if (!capture_stop) begin
        for (int c = 0; c < act; c++) begin
          if (capture_in.valid[c] && (model_q[c].size() < cap)) begin
            model_q[c].push_back(capture_in.data[c]);
            if (model_q[c].size() == cap) begin
              hit = 1'b1;
            end
          end
        end
      end
      if (hit) begin
        model_armed = 1'b0;
        model_full = 1'b1;
      end else if (capture_stop) begin
        model_armed = 1'b0;
      end
    end else if (capture_start) begin
      for (int c = 0; c < CHANNELS; c++) begin
        model_q[c].delete();
      end
      model_armed = 1'b1;
      model_full = 1'b0;
    end
  endtask

  // headers in channel order followed by each channel oldest first
  task automatic build_stream();
    int act;
    int total;
    int count;
    readout_word_s w;
    act = int'(active_channels);
    total = 0;
    count = 0;
    expected_stream.delete();
    for (int c = 0; c < act; c++) begin
      total += model_q[c].size();
    end
    for (int c = 0; c < act; c++) begin
      w.data = sample_t'(model_q[c].size());
      w.last = (c == act - 1) && (total == 0);
      expected_stream.push_back(w);
    end
    for (int c = 0; c < act; c++) begin
      for (int i = 0; i < model_q[c].size(); i++) begin
        count++;
        w.data = model_q[c][i];
        w.last = (count == total);
        expected_stream.push_back(w);
      end
    end
  endtask

  task automatic check_capture_state();
    for (int c = 0; c < CHANNELS; c++) begin
      check_value($sformatf("write_depth[%0d]", c), 32'(write_depth[c]),
                  32'(model_q[c].size()));
    end
    check_value("capture_armed", 32'(capture_armed), 32'(model_armed));
    check_value("capture_full", 32'(capture_full), 32'(model_full));
  endtask

`endif

// ==== testbench/sample_buffer_tb.sv ====
// testbench with clock, reset, capture and readout sequences, stream monitor and watchdog
`timescale 1ns/1ps

module sample_buffer_tb
  import sample_buffer_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int NUM_CASES = 16;
  localparam int MAX_STREAM = BANK_DEPTH * CHANNELS + CHANNELS;
  localparam int WATCHDOG_CYCLES = NUM_CASES * (BANK_DEPTH * CHANNELS + MAX_STREAM) * 4;

  // how a capture run ends
  localparam int CAP_STOP = 0;
  localparam int CAP_UNTIL_FULL = 1;
  localparam int CAP_SW_RESET = 2;

  logic capture_clk = 1'b0;
  logic readout_reset;
  capture_in_s capture_in;
  active_count_t active_channels;
  logic capture_start;
  logic capture_stop;
  logic capture_sw_reset;
  logic capture_full;
  logic capture_armed;
  depth_vector_t write_depth;
  logic readout_start;
  logic readout_sw_reset;
  logic readout_ready;
  logic readout_valid;
  readout_word_s readout_word;

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "sample_buffer_model.svh"

  sample_buffer dut_i (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .capture_in       (capture_in),
    .active_channels  (active_channels),
    .capture_start    (capture_start),
    .capture_stop     (capture_stop),
    .capture_sw_reset (capture_sw_reset),
    .capture_full     (capture_full),
    .capture_armed    (capture_armed),
    .write_depth      (write_depth),
    .readout_start    (readout_start),
    .readout_sw_reset (readout_sw_reset),
    .readout_ready    (readout_ready),
    .readout_valid    (readout_valid),
    .readout_word     (readout_word)
  );

  always #(CLK_PERIOD / 2) capture_clk = ~capture_clk;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge capture_clk);
    #1;
  endtask

  task automatic capture_edge();
    model_capture_edge();
    next_cycle();
    check_capture_state();
  endtask

  task automatic drive_random_samples();
    for (int c = 0; c < CHANNELS; c++) begin
      capture_in.valid[c] = ((rand_next() % 4) != 0);
      capture_in.data[c] = sample_t'(rand_next());
    end
  endtask

  task automatic run_capture(input int act, input int cycles, input int mode);
    int cap;
    int max_depth;
    active_channels = active_count_t'(act);
    capture_start = 1'b1;
    capture_edge();
    capture_start = 1'b0;
    if (mode == CAP_UNTIL_FULL) begin
      while (!model_full) begin
        drive_random_samples();
        capture_edge();
      end
      // samples offered after full must not land
      repeat (3) begin
        drive_random_samples();
        capture_edge();
      end
      cap = (BANK_DEPTH * CHANNELS) / act;
      max_depth = 0;
      for (int c = 0; c < act; c++) begin
        if (int'(write_depth[c]) > max_depth) begin
          max_depth = int'(write_depth[c]);
        end
      end
      check_value("full channel depth", 32'(max_depth), 32'(cap));
      check_value("capture_full", 32'(capture_full), 32'd1);
    end else begin
      repeat (cycles) begin
        drive_random_samples();
        capture_edge();
      end
      drive_random_samples();
      if (mode == CAP_SW_RESET) begin
        capture_sw_reset = 1'b1;
      end else begin
        capture_stop = 1'b1;
      end
      capture_edge();
      capture_stop = 1'b0;
      capture_sw_reset = 1'b0;
    end
    capture_in.valid = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // readout with stream monitor
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_readout(input bit abort);
    readout_word_s held;
    readout_word_s exp_word;
    bit held_valid;
    int sent;
    int abort_after;
    build_stream();
    sent = 0;
    held_valid = 1'b0;
    held = '0;
    abort_after = abort ? rand_range(0, expected_stream.size() - 1) : -1;
    readout_start = 1'b1;
    while (expected_stream.size() > 0) begin
      readout_ready = ((rand_next() % 3) != 0);
      // a stalled word stays put
      if (held_valid) begin
        check_value("readout_valid", 32'(readout_valid), 32'd1);
        check_value("held readout_word", 32'(readout_word), 32'(held));
      end
      if (readout_valid && readout_ready) begin
        exp_word = expected_stream.pop_front();
        check_value("readout_word", 32'(readout_word), 32'(exp_word));
        sent++;
      end
      held_valid = readout_valid && !readout_ready;
      held = readout_word;
      next_cycle();
      readout_start = 1'b0;
      if (sent == abort_after) begin
        readout_ready = 1'b0;
        readout_sw_reset = 1'b1;
        next_cycle();
        readout_sw_reset = 1'b0;
        check_value("readout_valid after abort", 32'(readout_valid), 32'd0);
        return;
      end
    end
    // nothing may follow the last word
    readout_ready = 1'b1;
    repeat (READ_LATENCY + 2) begin
      check_value("readout_valid after last", 32'(readout_valid), 32'd0);
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    readout_reset = 1'b1;
    capture_in = '0;
    active_channels = active_count_t'(1);
    capture_start = 1'b0;
    capture_stop = 1'b0;
    capture_sw_reset = 1'b0;
    readout_start = 1'b0;
    readout_sw_reset = 1'b0;
    readout_ready = 1'b0;
    repeat (5) @(posedge capture_clk);
    #1;
    readout_reset = 1'b0;
    check_capture_state();
    check_value("readout_valid after reset", 32'(readout_valid), 32'd0);

    // short random captures
    for (int i = 0; i < 3; i++) begin
      run_capture(1 << i, rand_range(5, 20), CAP_STOP);
      run_readout(1'b0);
    end
    // start then stop at once
    for (int i = 0; i < 3; i++) begin
      run_capture(1 << i, 0, CAP_STOP);
      run_readout(1'b0);
    end
    // capture until full
    for (int i = 0; i < 3; i++) begin
      run_capture(1 << i, 0, CAP_UNTIL_FULL);
      run_readout(1'b0);
    end

    // capture software reset in mid capture and while full
    run_capture(2, rand_range(5, 20), CAP_SW_RESET);
    run_capture(4, 0, CAP_UNTIL_FULL);
    capture_sw_reset = 1'b1;
    capture_edge();
    capture_sw_reset = 1'b0;
    run_capture(2, rand_range(5, 20), CAP_STOP);
    run_readout(1'b0);

    // readout abort followed by the same stream again
    for (int i = 0; i < 2; i++) begin
      run_capture(4 >> i, rand_range(5, 20), CAP_STOP);
      run_readout(1'b1);
      run_readout(1'b0);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule
